// ==== dv/rv_decode_sva.sv ====
`include "rv_decode_params.svh"

module rv_decode_sva (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic [`RVD_INSTR_W-1:0] instr_i,
    input  logic                    instr_valid_i,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  rv_decode_pkg::uop_t     uop_o
);

    int                      fail_cnt = 0;
    logic [`RVD_INSTR_W-1:0] instr_q;
    logic                    consume;
    logic                    is_addi;
    logic                    is_beq;
    logic                    is_bad;

    assign consume = rstn_i && instr_valid_i && !flush_i && !stall_i;
    assign is_addi = (instr_i[6:0] == 7'h13) && (instr_i[14:12] == 3'b000);
    assign is_beq  = (instr_i[6:0] == 7'h63) && (instr_i[14:12] == 3'b000);
    assign is_bad  = (instr_i == '0)                                    // All-zero word.
                     || ((instr_i[6:0] == 7'h73) && (instr_i[14:12] == 3'b001));   // CSRRW.

    always_ff @(posedge clk_i)
    begin
        instr_q <= instr_i;                                             // Word of the last edge.
    end

    function automatic void flag(input string what);
        fail_cnt++;
        $error("mismatch at %0t: %s", $time, what);
    endfunction

    //////////////////////////////
    // Control and handshake
    //////////////////////////////

    a_reset : assert property (@(posedge clk_i) !rstn_i |=>
        !uop_o.valid && !uop_o.illegal && (uop_o.tag == '0))
        else flag("uop_o not cleared by reset");

    a_hold : assert property (@(posedge clk_i) disable iff (!rstn_i)
        stall_i |=> $stable(uop_o))
        else flag("uop_o changed while stalled");

    a_valid : assert property (@(posedge clk_i) disable iff (!rstn_i)
        !stall_i |=> uop_o.valid == $past(instr_valid_i && !flush_i))
        else flag("uop_o.valid differs from fetch valid and flush");

    // A legal micro-op leaving the register moves the tag on by one.
    a_tag : assert property (@(posedge clk_i) disable iff (!rstn_i)
        !stall_i |=> uop_o.tag == $past(uop_o.tag)
            + {{(`RVD_TAG_W-1){1'b0}}, $past(uop_o.valid && !uop_o.illegal)})
        else flag("tag did not follow the legal micro-op count");

    //////////////////////////////
    // Decoded fields
    //////////////////////////////

    a_addi : assert property (@(posedge clk_i) disable iff (!rstn_i)
        consume && is_addi |=> (uop_o.rd == instr_q[11:7]) && (uop_o.rs1 == instr_q[19:15])
            && (uop_o.imm == {{20{instr_q[31]}}, instr_q[31:20]})
            && (uop_o.alu == rv_decode_pkg::ALU_ADD) && (uop_o.wb_sel == rv_decode_pkg::WB_ALU))
        else flag("ADDI micro-op fields");

    a_beq : assert property (@(posedge clk_i) disable iff (!rstn_i)
        consume && is_beq |=> (uop_o.br_kind == rv_decode_pkg::BR_BEQ)
            && (uop_o.imm == {{20{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0}))
        else flag("BEQ immediate or branch kind");

    a_illegal : assert property (@(posedge clk_i) disable iff (!rstn_i)
        consume && is_bad |=> uop_o.illegal && uop_o.valid && !uop_o.rd_en)
        else flag("illegal word not flagged");

endmodule

bind rv_decode_top rv_decode_sva rv_decode_sva_inst (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall_i),
    .flush_i       (flush_i),
    .uop_o         (uop_o)
);

// ==== dv/rv_decode_tb.sv ====
`include "rv_decode_params.svh"

module rv_decode_tb;

    localparam int N_PASSES   = 4;
    localparam int N_KINDS    = 14;
    localparam int STALL_WAIT = 64;
    localparam int DRAIN_WAIT = 8;

    logic                    clk_i;
    logic                    rstn_i;
    logic [`RVD_INSTR_W-1:0] instr_i;
    logic [`RVD_XLEN-1:0]    pc_i;
    logic                    instr_valid_i;
    logic                    pred_taken_i;
    logic                    stall_i;
    logic                    flush_i;
    rv_decode_pkg::uop_t     uop_o;
    logic [31:0]             lfsr_q;

    rv_decode_top rv_decode_top_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .instr_valid_i (instr_valid_i),
        .pred_taken_i  (pred_taken_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .uop_o         (uop_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    // Galois LFSR stepped once per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            bits   = {bits[30:0], lfsr_q[0]};
        end
        return bits;
    endfunction

    // Random word r supplies rd, rs1, rs2 and the immediate bits.
    function automatic logic [31:0] encode(input int kind, input logic [31:0] r);
        case (kind)
            0:       return {r[31:15], 3'b000, r[11:7], 7'h13};            // ADDI.
            1:       return {r[31:15], 3'b000, r[11:7], 7'h63};            // BEQ.
            2:       return {7'h00, r[24:15], 3'b000, r[11:7], 7'h33};     // ADD.
            3:       return {7'h20, r[24:15], 3'b000, r[11:7], 7'h33};     // SUB.
            4:       return {r[31:15], 3'b010, r[11:7], 7'h03};            // LW.
            5:       return {r[31:15], 3'b010, r[11:7], 7'h23};            // SW.
            6:       return {r[31:7], 7'h37};                              // LUI.
            7:       return {r[31:7], 7'h6f};                              // JAL.
            8:       return {r[31:15], 3'b000, r[11:7], 7'h67};            // JALR.
            9:       return {7'h20, r[24:15], 3'b101, r[11:7], 7'h13};     // SRAI.
            10:      return {r[31:15], 3'b011, r[11:7], 7'h13};            // SLTIU.
            11:      return 32'h0000_0000;
            12:      return {r[31:15], 3'b001, r[11:7], 7'h73};            // CSRRW.
            default: return 32'h0000_0073;                                 // ECALL.
        endcase
    endfunction

    // Present one word until an edge takes it with stall and flush low.
    task automatic issue(input logic [31:0] word);
        logic [31:0] r;
        int          tries;
        tries = 0;
        r             = take_bits(1);
        pred_taken_i  = r[0];
        instr_i       = word;
        instr_valid_i = 1'b1;
        do
        begin
            if (tries == STALL_WAIT)
            begin
                stop_with_failure("instruction was not consumed before the timeout");
            end
            r       = take_bits(4);
            stall_i = &r[1:0];
            flush_i = &r[3:2];
            @(posedge clk_i);
            #1;
            tries++;
        end
        while (stall_i || flush_i);
    endtask

    always @(negedge clk_i)
    begin
        if (rv_decode_top_inst.rv_decode_sva_inst.fail_cnt != 0)
        begin
            stop_with_failure("an assertion on the decode output failed");
        end
    end

    //////////////////////////////
    // Sequence
    //////////////////////////////

    initial
    begin
        logic [31:0] r;
        int          wait_cnt;
        lfsr_q        = 32'h2471c49b;
        rstn_i        = 1'b0;
        instr_i       = `RVD_NOP_INSTR;
        pc_i          = `RVD_RESET_PC;
        instr_valid_i = 1'b0;
        pred_taken_i  = 1'b0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        repeat (16) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        for (int pass = 0; pass < N_PASSES; pass++)
        begin
            for (int kind = 0; kind < N_KINDS; kind++)
            begin
                r = take_bits(32);
                issue(encode(kind, r));
                pc_i = pc_i + 32'd4;
                r = take_bits(2);
                if (r[1:0] == 2'b00)
                begin
                    instr_valid_i = 1'b0;                                  // Fetch bubble.
                    stall_i       = 1'b0;
                    flush_i       = 1'b0;
                    @(posedge clk_i);
                    #1;
                end
            end
        end

        instr_valid_i = 1'b0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        wait_cnt      = 0;
        do
        begin
            @(posedge clk_i);
            #1;
            wait_cnt++;
        end
        while (uop_o.valid && (wait_cnt < DRAIN_WAIT));

        if (uop_o.valid)
        begin
            stop_with_failure("uop_o stayed valid after fetch went idle");
        end
        else if (rv_decode_top_inst.rv_decode_sva_inst.fail_cnt == 0)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            stop_with_failure("an assertion on the decode output failed");
        end
    end

endmodule

// ==== logic/imm_gen.sv ====
`include "rv_decode_params.svh"

module imm_gen (
    input  rv_decode_pkg::instr_u       instr_i,
    input  rv_decode_pkg::instr_class_e cls_i,
    output logic [`RVD_XLEN-1:0]        imm_o
);

    rv_decode_pkg::imm_fmt_e fmt;

    always_comb
    begin
        case (cls_i)
            rv_decode_pkg::CLS_LUI, rv_decode_pkg::CLS_AUIPC:
                fmt = rv_decode_pkg::IMM_U;
            rv_decode_pkg::CLS_JAL:
                fmt = rv_decode_pkg::IMM_J;
            rv_decode_pkg::CLS_BEQ, rv_decode_pkg::CLS_BNE, rv_decode_pkg::CLS_BLT,
            rv_decode_pkg::CLS_BGE, rv_decode_pkg::CLS_BLTU, rv_decode_pkg::CLS_BGEU:
                fmt = rv_decode_pkg::IMM_B;
            rv_decode_pkg::CLS_SB, rv_decode_pkg::CLS_SH, rv_decode_pkg::CLS_SW:
                fmt = rv_decode_pkg::IMM_S;
            rv_decode_pkg::CLS_SLLI, rv_decode_pkg::CLS_SRLI, rv_decode_pkg::CLS_SRAI:
                fmt = rv_decode_pkg::IMM_SHAMT;
            rv_decode_pkg::CLS_JALR, rv_decode_pkg::CLS_LB, rv_decode_pkg::CLS_LH,
            rv_decode_pkg::CLS_LW, rv_decode_pkg::CLS_LBU, rv_decode_pkg::CLS_LHU,
            rv_decode_pkg::CLS_ADDI, rv_decode_pkg::CLS_SLTI, rv_decode_pkg::CLS_SLTIU,
            rv_decode_pkg::CLS_XORI, rv_decode_pkg::CLS_ORI, rv_decode_pkg::CLS_ANDI:
                fmt = rv_decode_pkg::IMM_I;                 // SLTIU sign-extends as well.
            default:
                fmt = rv_decode_pkg::IMM_NONE;
        endcase
    end

    always_comb
    begin
        case (fmt)
            rv_decode_pkg::IMM_I:
                imm_o = {{(`RVD_XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
            rv_decode_pkg::IMM_S:
                imm_o = {{(`RVD_XLEN-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi,
                         instr_i.s.imm_lo};
            rv_decode_pkg::IMM_B:
                imm_o = {{(`RVD_XLEN-12){instr_i.b.imm_12}}, instr_i.b.imm_11,
                         instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
            rv_decode_pkg::IMM_U:
                imm_o = {instr_i.u.imm, 12'b0};
            rv_decode_pkg::IMM_J:
                imm_o = {{(`RVD_XLEN-20){instr_i.j.imm_20}}, instr_i.j.imm_19_12,
                         instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};
            rv_decode_pkg::IMM_SHAMT:
                imm_o = {{(`RVD_XLEN-5){1'b0}}, instr_i.i.imm[4:0]};
            default:
                imm_o = '0;
        endcase
    end

endmodule

// ==== logic/instr_matcher.sv ====
`include "rv_decode_params.svh"

module instr_matcher (
    input  rv_decode_pkg::instr_u       instr_i,
    input  logic                        valid_i,
    input  logic                        flush_i,
    output rv_decode_pkg::instr_class_e cls_o,
    output logic                        active_o
);

    logic [`RVD_INSTR_W-1:0]           word;
    logic [rv_decode_pkg::N_RULES-1:0] hit;

    assign word     = instr_i;
    assign active_o = valid_i && !flush_i;  // Flush kills the incoming word.

    //////////////////////////////
    // One comparator per rule
    //////////////////////////////

    for (genvar g = 0; g < rv_decode_pkg::N_RULES; g++)
    begin : g_rule
        assign hit[g] = (word & rv_decode_pkg::MATCH_TABLE[g].mask)
                        == rv_decode_pkg::MATCH_TABLE[g].value;
    end

    // The rule set is disjoint, so at most one hit is set.
    always_comb
    begin
        cls_o = rv_decode_pkg::CLS_NONE;
        for (int i = 0; i < rv_decode_pkg::N_RULES; i++)
        begin
            if (active_o && hit[i])
            begin
                cls_o = rv_decode_pkg::MATCH_TABLE[i].cls;
            end
        end
    end

endmodule

// ==== logic/rv_decode_params.svh ====
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// Datapath and PC width.
`define RVD_XLEN      32
`define RVD_INSTR_W   32
`define RVD_REG_AW    5
`define RVD_CLS_W     6

// Rolling micro-op tag that wraps at 2**RVD_TAG_W.
`define RVD_TAG_W     4

// Fetch side defaults.
`define RVD_RESET_PC  32'h0000_0000
`define RVD_NOP_INSTR 32'h0000_0013

`endif

// ==== logic/rv_decode_pkg.sv ====
`include "rv_decode_params.svh"

package rv_decode_pkg;

    //////////////////////////////
    // Instruction word views
    //////////////////////////////

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`RVD_REG_AW-1:0] rs2;
        logic [`RVD_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [`RVD_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`RVD_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [`RVD_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`RVD_REG_AW-1:0] rs2;
        logic [`RVD_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`RVD_REG_AW-1:0] rs2;
        logic [`RVD_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;
        logic [6:0]             opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm;
        logic [`RVD_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm_20;
        logic [9:0]             imm_10_1;
        logic                   imm_11;
        logic [7:0]             imm_19_12;
        logic [`RVD_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    //////////////////////////////
    // Decode enumerations
    //////////////////////////////

    typedef enum logic [`RVD_CLS_W-1:0] {
        CLS_NONE,
        CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
        CLS_BEQ, CLS_BNE, CLS_BLT, CLS_BGE, CLS_BLTU, CLS_BGEU,
        CLS_LB, CLS_LH, CLS_LW, CLS_LBU, CLS_LHU,
        CLS_SB, CLS_SH, CLS_SW,
        CLS_ADDI, CLS_SLTI, CLS_SLTIU, CLS_XORI, CLS_ORI, CLS_ANDI,
        CLS_SLLI, CLS_SRLI, CLS_SRAI,
        CLS_ADD, CLS_SUB, CLS_SLT, CLS_SLTU, CLS_XOR, CLS_OR, CLS_AND
    } instr_class_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
    } imm_fmt_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        OPND_RS1, OPND_RS2, OPND_IMM, OPND_PC
    } opnd_sel_e;

    typedef enum logic [2:0] {
        WB_NONE, WB_ALU, WB_IMM, WB_LINK, WB_MEM
    } wb_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_kind_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_kind_e;

    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        logic                   taken;                // Fetch predicted taken.
        logic [`RVD_XLEN-1:0]   pc;
        logic [`RVD_TAG_W-1:0]  tag;
        logic [`RVD_REG_AW-1:0] rs1;
        logic                   rs1_en;
        logic [`RVD_REG_AW-1:0] rs2;
        logic                   rs2_en;
        logic [`RVD_REG_AW-1:0] rd;
        logic                   rd_en;
        logic [`RVD_XLEN-1:0]   imm;
        alu_op_e                alu;
        opnd_sel_e              op1_sel;
        opnd_sel_e              op2_sel;
        wb_sel_e                wb_sel;
        br_kind_e               br_kind;
        mem_kind_e              mem_kind;
    } uop_t;

    //////////////////////////////
    // Mask and match rules
    //////////////////////////////

    typedef struct packed {
        instr_class_e             cls;
        logic [`RVD_INSTR_W-1:0]  mask;
        logic [`RVD_INSTR_W-1:0]  value;
    } match_rule_t;

    localparam logic [`RVD_INSTR_W-1:0] MASK_OPC = 32'h0000_007f; // Opcode only.
    localparam logic [`RVD_INSTR_W-1:0] MASK_F3  = 32'h0000_707f; // Plus funct3.
    localparam logic [`RVD_INSTR_W-1:0] MASK_F7  = 32'hfe00_707f; // Plus funct7.

    localparam int N_RULES = 34;

    localparam match_rule_t MATCH_TABLE [N_RULES] = '{
        '{CLS_LUI,   MASK_OPC, 32'h0000_0037},
        '{CLS_AUIPC, MASK_OPC, 32'h0000_0017},
        '{CLS_JAL,   MASK_OPC, 32'h0000_006f},
        '{CLS_JALR,  MASK_F3,  32'h0000_0067},
        '{CLS_BEQ,   MASK_F3,  32'h0000_0063},
        '{CLS_BNE,   MASK_F3,  32'h0000_1063},
        '{CLS_BLT,   MASK_F3,  32'h0000_4063},
        '{CLS_BGE,   MASK_F3,  32'h0000_5063},
        '{CLS_BLTU,  MASK_F3,  32'h0000_6063},
        '{CLS_BGEU,  MASK_F3,  32'h0000_7063},
        '{CLS_LB,    MASK_F3,  32'h0000_0003},
        '{CLS_LH,    MASK_F3,  32'h0000_1003},
        '{CLS_LW,    MASK_F3,  32'h0000_2003},
        '{CLS_LBU,   MASK_F3,  32'h0000_4003},
        '{CLS_LHU,   MASK_F3,  32'h0000_5003},
        '{CLS_SB,    MASK_F3,  32'h0000_0023},
        '{CLS_SH,    MASK_F3,  32'h0000_1023},
        '{CLS_SW,    MASK_F3,  32'h0000_2023},
        '{CLS_ADDI,  MASK_F3,  32'h0000_0013},
        '{CLS_SLTI,  MASK_F3,  32'h0000_2013},
        '{CLS_SLTIU, MASK_F3,  32'h0000_3013},
        '{CLS_XORI,  MASK_F3,  32'h0000_4013},
        '{CLS_ORI,   MASK_F3,  32'h0000_6013},
        '{CLS_ANDI,  MASK_F3,  32'h0000_7013},
        '{CLS_SLLI,  MASK_F7,  32'h0000_1013},
        '{CLS_SRLI,  MASK_F7,  32'h0000_5013},
        '{CLS_SRAI,  MASK_F7,  32'h4000_5013},
        '{CLS_ADD,   MASK_F7,  32'h0000_0033},
        '{CLS_SUB,   MASK_F7,  32'h4000_0033},
        '{CLS_SLT,   MASK_F7,  32'h0000_2033},
        '{CLS_SLTU,  MASK_F7,  32'h0000_3033},
        '{CLS_XOR,   MASK_F7,  32'h0000_4033},
        '{CLS_OR,    MASK_F7,  32'h0000_6033},
        '{CLS_AND,   MASK_F7,  32'h0000_7033}
    };

endpackage

// ==== logic/rv_decode_top.sv ====
`include "rv_decode_params.svh"

module rv_decode_top (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic [`RVD_INSTR_W-1:0] instr_i,
    input  logic [`RVD_XLEN-1:0]    pc_i,
    input  logic                    instr_valid_i,
    input  logic                    pred_taken_i,
    input  logic                    stall_i,
    input  logic                    flush_i,
    output rv_decode_pkg::uop_t     uop_o
);

    rv_decode_pkg::instr_class_e cls;
    logic                        active;
    logic [`RVD_XLEN-1:0]        imm;
    rv_decode_pkg::uop_t         uop_next;

    //////////////////////////////
    // Combinational decode
    //////////////////////////////

    instr_matcher instr_matcher_inst (
        .instr_i  (instr_i),
        .valid_i  (instr_valid_i),
        .flush_i  (flush_i),
        .cls_o    (cls),
        .active_o (active)
    );

    imm_gen imm_gen_inst (
        .instr_i (instr_i),
        .cls_i   (cls),
        .imm_o   (imm)
    );

    uop_builder uop_builder_inst (
        .cls_i    (cls),
        .active_i (active),
        .instr_i  (instr_i),
        .imm_i    (imm),
        .pc_i     (pc_i),
        .taken_i  (pred_taken_i),
        .uop_o    (uop_next)
    );

    //////////////////////////////
    // Pipeline register
    //////////////////////////////

    uop_stage_reg uop_stage_reg_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .stall_i (stall_i),
        .uop_i   (uop_next),
        .uop_o   (uop_o)
    );

endmodule

// ==== logic/uop_builder.sv ====
`include "rv_decode_params.svh"

module uop_builder (
    input  rv_decode_pkg::instr_class_e cls_i,
    input  logic                        active_i,
    input  rv_decode_pkg::instr_u       instr_i,
    input  logic [`RVD_XLEN-1:0]        imm_i,
    input  logic [`RVD_XLEN-1:0]        pc_i,
    input  logic                        taken_i,
    output rv_decode_pkg::uop_t         uop_o
);

    always_comb
    begin
        uop_o         = '0;                          // Tag is filled in by the stage register.
        uop_o.valid   = active_i;
        uop_o.illegal = active_i && (cls_i == rv_decode_pkg::CLS_NONE);
        uop_o.taken   = taken_i;
        uop_o.pc      = pc_i;
        uop_o.imm     = imm_i;                       // Zero for CLS_NONE.

        //////////////////////////////
        // Operands and writeback
        //////////////////////////////
        case (cls_i)
            rv_decode_pkg::CLS_LUI:
            begin
                uop_o.rd_en   = 1'b1;
                uop_o.op1_sel = rv_decode_pkg::OPND_IMM;
                uop_o.wb_sel  = rv_decode_pkg::WB_IMM;
            end
            rv_decode_pkg::CLS_AUIPC:
            begin
                uop_o.rd_en   = 1'b1;
                uop_o.op1_sel = rv_decode_pkg::OPND_PC;
                uop_o.op2_sel = rv_decode_pkg::OPND_IMM;
                uop_o.wb_sel  = rv_decode_pkg::WB_ALU;
            end
            rv_decode_pkg::CLS_JAL, rv_decode_pkg::CLS_JALR:
            begin
                uop_o.rs1_en  = (cls_i == rv_decode_pkg::CLS_JALR);
                uop_o.rd_en   = 1'b1;
                uop_o.wb_sel  = rv_decode_pkg::WB_LINK;  // Return address.
            end
            rv_decode_pkg::CLS_BEQ, rv_decode_pkg::CLS_BNE, rv_decode_pkg::CLS_BLT,
            rv_decode_pkg::CLS_BGE, rv_decode_pkg::CLS_BLTU, rv_decode_pkg::CLS_BGEU:
            begin
                uop_o.rs1_en  = 1'b1;
                uop_o.rs2_en  = 1'b1;
                uop_o.op2_sel = rv_decode_pkg::OPND_RS2;
            end
            rv_decode_pkg::CLS_LB, rv_decode_pkg::CLS_LH, rv_decode_pkg::CLS_LW,
            rv_decode_pkg::CLS_LBU, rv_decode_pkg::CLS_LHU:
            begin
                uop_o.rs1_en  = 1'b1;
                uop_o.rd_en   = 1'b1;
                uop_o.wb_sel  = rv_decode_pkg::WB_MEM;
            end
            rv_decode_pkg::CLS_SB, rv_decode_pkg::CLS_SH, rv_decode_pkg::CLS_SW:
            begin
                uop_o.rs1_en  = 1'b1;
                uop_o.rs2_en  = 1'b1;
            end
            rv_decode_pkg::CLS_ADDI, rv_decode_pkg::CLS_SLTI, rv_decode_pkg::CLS_SLTIU,
            rv_decode_pkg::CLS_XORI, rv_decode_pkg::CLS_ORI, rv_decode_pkg::CLS_ANDI,
            rv_decode_pkg::CLS_SLLI, rv_decode_pkg::CLS_SRLI, rv_decode_pkg::CLS_SRAI:
            begin
                uop_o.rs1_en  = 1'b1;
                uop_o.rd_en   = 1'b1;
                uop_o.op2_sel = rv_decode_pkg::OPND_IMM;
                uop_o.wb_sel  = rv_decode_pkg::WB_ALU;
            end
            rv_decode_pkg::CLS_ADD, rv_decode_pkg::CLS_SUB, rv_decode_pkg::CLS_SLT,
            rv_decode_pkg::CLS_SLTU, rv_decode_pkg::CLS_XOR, rv_decode_pkg::CLS_OR,
            rv_decode_pkg::CLS_AND:
            begin
                uop_o.rs1_en  = 1'b1;
                uop_o.rs2_en  = 1'b1;
                uop_o.rd_en   = 1'b1;
                uop_o.op2_sel = rv_decode_pkg::OPND_RS2;
                uop_o.wb_sel  = rv_decode_pkg::WB_ALU;
            end
            default:
            begin
                uop_o.rd_en   = 1'b0;                // Illegal or idle slot.
            end
        endcase

        uop_o.rs1 = uop_o.rs1_en ? instr_i.r.rs1 : '0;
        uop_o.rs2 = uop_o.rs2_en ? instr_i.s.rs2 : '0;
        uop_o.rd  = uop_o.rd_en  ? instr_i.i.rd  : '0;

        case (cls_i)
            rv_decode_pkg::CLS_AUIPC, rv_decode_pkg::CLS_ADDI, rv_decode_pkg::CLS_ADD:
                uop_o.alu = rv_decode_pkg::ALU_ADD;
            rv_decode_pkg::CLS_SUB:  uop_o.alu = rv_decode_pkg::ALU_SUB;
            rv_decode_pkg::CLS_ANDI, rv_decode_pkg::CLS_AND:  uop_o.alu = rv_decode_pkg::ALU_AND;
            rv_decode_pkg::CLS_ORI, rv_decode_pkg::CLS_OR:    uop_o.alu = rv_decode_pkg::ALU_OR;
            rv_decode_pkg::CLS_XORI, rv_decode_pkg::CLS_XOR:  uop_o.alu = rv_decode_pkg::ALU_XOR;
            rv_decode_pkg::CLS_SLTI, rv_decode_pkg::CLS_SLT:  uop_o.alu = rv_decode_pkg::ALU_SLT;
            rv_decode_pkg::CLS_SLTIU, rv_decode_pkg::CLS_SLTU:
                uop_o.alu = rv_decode_pkg::ALU_SLTU;
            rv_decode_pkg::CLS_SLLI: uop_o.alu = rv_decode_pkg::ALU_SLL;
            rv_decode_pkg::CLS_SRLI: uop_o.alu = rv_decode_pkg::ALU_SRL;
            rv_decode_pkg::CLS_SRAI: uop_o.alu = rv_decode_pkg::ALU_SRA;
            default:                 uop_o.alu = rv_decode_pkg::ALU_NOP;
        endcase

        case (cls_i)
            rv_decode_pkg::CLS_JAL:  uop_o.br_kind = rv_decode_pkg::BR_JAL;
            rv_decode_pkg::CLS_JALR: uop_o.br_kind = rv_decode_pkg::BR_JALR;
            rv_decode_pkg::CLS_BEQ:  uop_o.br_kind = rv_decode_pkg::BR_BEQ;
            rv_decode_pkg::CLS_BNE:  uop_o.br_kind = rv_decode_pkg::BR_BNE;
            rv_decode_pkg::CLS_BLT:  uop_o.br_kind = rv_decode_pkg::BR_BLT;
            rv_decode_pkg::CLS_BGE:  uop_o.br_kind = rv_decode_pkg::BR_BGE;
            rv_decode_pkg::CLS_BLTU: uop_o.br_kind = rv_decode_pkg::BR_BLTU;
            rv_decode_pkg::CLS_BGEU: uop_o.br_kind = rv_decode_pkg::BR_BGEU;
            default:                 uop_o.br_kind = rv_decode_pkg::BR_NONE;
        endcase

        case (cls_i)
            rv_decode_pkg::CLS_LB:   uop_o.mem_kind = rv_decode_pkg::MEM_LB;
            rv_decode_pkg::CLS_LH:   uop_o.mem_kind = rv_decode_pkg::MEM_LH;
            rv_decode_pkg::CLS_LW:   uop_o.mem_kind = rv_decode_pkg::MEM_LW;
            rv_decode_pkg::CLS_LBU:  uop_o.mem_kind = rv_decode_pkg::MEM_LBU;
            rv_decode_pkg::CLS_LHU:  uop_o.mem_kind = rv_decode_pkg::MEM_LHU;
            rv_decode_pkg::CLS_SB:   uop_o.mem_kind = rv_decode_pkg::MEM_SB;
            rv_decode_pkg::CLS_SH:   uop_o.mem_kind = rv_decode_pkg::MEM_SH;
            rv_decode_pkg::CLS_SW:   uop_o.mem_kind = rv_decode_pkg::MEM_SW;
            default:                 uop_o.mem_kind = rv_decode_pkg::MEM_NONE;
        endcase
    end

endmodule

// ==== logic/uop_stage_reg.sv ====
`include "rv_decode_params.svh"

module uop_stage_reg (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                stall_i,
    input  rv_decode_pkg::uop_t uop_i,
    output rv_decode_pkg::uop_t uop_o
);

    logic [`RVD_TAG_W-1:0] tag_q;
    rv_decode_pkg::uop_t   uop_d;
    rv_decode_pkg::uop_t   uop_q;

    always_comb
    begin
        uop_d     = uop_i;
        uop_d.tag = tag_q;                            // Tag before the increment.
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            uop_q <= '0;
            tag_q <= '0;
        end
        else if (!stall_i)
        begin
            uop_q <= uop_d;
            if (uop_i.valid && !uop_i.illegal)
            begin
                tag_q <= tag_q + 1'b1;                // Wraps at 16.
            end
        end
    end

    assign uop_o = uop_q;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing \
    -f src.f \
    --top-module rv_decode_tb \
    -o rv_decode_sim

./obj_dir/rv_decode_sim +verilator+error+limit+100

// ==== src.f ====
+incdir+logic
logic/rv_decode_pkg.sv
logic/instr_matcher.sv
logic/imm_gen.sv
logic/uop_builder.sv
logic/uop_stage_reg.sv
logic/rv_decode_top.sv
dv/rv_decode_sva.sv
dv/rv_decode_tb.sv
